// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define DATA_W      8
`define OPC_W       4
`define OP_W        5
`define RB_SEL_W    3

`define INT_VECTOR  8'h80  // irq entry point

// upper nibble of the instruction byte
`define OPC_ADD     4'b0000
`define OPC_SUB     4'b0001
`define OPC_AND     4'b0010
`define OPC_XOR     4'b0011
`define OPC_LDI     4'b0100
`define OPC_XCH     4'b0101
`define OPC_JMP     4'b0110
`define OPC_RETI    4'b0111
`define OPC_LD      4'b1000
`define OPC_ST      4'b1001
`define OPC_EINT    4'b1010
`define OPC_MOV     4'b1011

// ctrl.op codes, bit 4 clear means alu function in the low nibble
`define OP_INT_VEC     5'b10000
`define OP_JMP_RN      5'b10001
`define OP_RETI        5'b10010
`define OP_STORE_DATA  5'b11000
`define OP_ADDR_RN     5'b11110
`define OP_PC_OUT      5'b11111

// reg_bank write selects, destination last
`define RB_ALU_R0   3'b000
`define RB_BUS_R0   3'b001
`define RB_R0_RN    3'b010
`define RB_RN_T     3'b011
`define RB_T_R0     3'b100

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// controller outputs, one 16-bit word
	typedef struct packed {
		logic [1:0]             spare;   // pads to 16 bits
		logic [`OP_W-1:0]       op;
		logic                   ir_we;
		logic                   pc_we;
		logic [`RB_SEL_W-1:0]   rb_sel;
		logic                   rb_we;
		logic                   sp_we;   // pc into link register
		logic                   mem_we;
		logic                   ale;
	} ctrl_t;

	// multiplexed address/data bus
	typedef struct packed {
		logic [`DATA_W-1:0]     ad;
		logic                   ale;
		logic                   we;
	} bus_t;

	// same byte seen as register form or immediate form
	typedef union packed {
		struct packed {
			logic [`OPC_W-1:0]  opcode;
			logic [1:0]         rsvd;
			logic [1:0]         rn;
		} as_reg;
		struct packed {
			logic [`OPC_W-1:0]  opcode;
			logic [3:0]         imm;
		} as_imm;
	} instr_t;

endpackage

`default_nettype wire

// File: source/up_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module up_controller (
	input  logic                clk,
	input  logic                nRst,
	input  logic                irq,
	input  logic [`OPC_W-1:0]   opcode,
	output cpu_pkg::ctrl_t      ctrl
);

	localparam logic [2:0] FETCH_LATCH = 3'd0;
	localparam logic [2:0] FETCH_READ  = 3'd1;
	localparam logic [2:0] EX1         = 3'd2;
	localparam logic [2:0] EX2         = 3'd3;
	localparam logic [2:0] EX3         = 3'd4;

	logic [2:0] state;
	logic       started;    // low until first edge after reset
	logic       irq_q;
	logic       irq_pend;
	logic       int_en;
	logic       irq_rise;
	logic       irq_take;

	assign irq_rise = irq & ~irq_q;
	assign irq_take = (state == FETCH_LATCH) & started & int_en & (irq_pend | irq_rise);

	always_comb begin
		ctrl        = '0;
		ctrl.op     = {1'b0, opcode};
		ctrl.rb_sel = `RB_ALU_R0;
		case (state)
			FETCH_LATCH: begin
				if (irq_take) begin
					// save pc, jump to vector, refetch next cycle
					ctrl.op    = `OP_INT_VEC;
					ctrl.pc_we = 1'b1;
					ctrl.sp_we = 1'b1;
				end else if (started) begin
					ctrl.op  = `OP_PC_OUT;
					ctrl.ale = 1'b1;
				end
			end
			FETCH_READ: begin
				ctrl.op    = `OP_PC_OUT;
				ctrl.ir_we = 1'b1;
				ctrl.pc_we = 1'b1;
			end
			EX1: begin
				case (opcode)
					`OPC_ADD, `OPC_SUB, `OPC_AND, `OPC_XOR, `OPC_LDI:
						ctrl.rb_we = 1'b1;    // alu result to r0
					`OPC_XCH: begin
						ctrl.rb_sel = `RB_RN_T;
						ctrl.rb_we  = 1'b1;
					end
					`OPC_JMP: begin
						ctrl.op    = `OP_JMP_RN;
						ctrl.pc_we = 1'b1;
					end
					`OPC_RETI: begin
						ctrl.op    = `OP_RETI;
						ctrl.pc_we = 1'b1;
					end
					`OPC_LD, `OPC_ST: begin
						ctrl.op  = `OP_ADDR_RN;
						ctrl.ale = 1'b1;
					end
					`OPC_MOV: begin
						ctrl.rb_sel = `RB_R0_RN;
						ctrl.rb_we  = 1'b1;
					end
					default: ;    // eint handled below, nop
				endcase
			end
			EX2: begin
				case (opcode)
					`OPC_XCH: begin
						ctrl.rb_sel = `RB_R0_RN;
						ctrl.rb_we  = 1'b1;
					end
					`OPC_LD: begin
						ctrl.rb_sel = `RB_BUS_R0;
						ctrl.rb_we  = 1'b1;
					end
					`OPC_ST: begin
						ctrl.op     = `OP_STORE_DATA;
						ctrl.mem_we = 1'b1;
					end
					default: ;
				endcase
			end
			EX3: begin
				if (opcode == `OPC_XCH) begin
					ctrl.rb_sel = `RB_T_R0;
					ctrl.rb_we  = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state    <= FETCH_LATCH;
			started  <= 1'b0;
			irq_q    <= 1'b0;
			irq_pend <= 1'b0;
			int_en   <= 1'b0;
		end else begin
			started <= 1'b1;
			irq_q   <= irq;

			// hold an edge seen mid-instruction until the next fetch
			if (irq_take || !int_en)
				irq_pend <= 1'b0;
			else if (irq_rise)
				irq_pend <= 1'b1;

			case (state)
				FETCH_LATCH: begin
					if (started && !irq_take)
						state <= FETCH_READ;
				end
				FETCH_READ: state <= EX1;
				EX1: begin
					case (opcode)
						`OPC_XCH, `OPC_LD, `OPC_ST: state <= EX2;
						`OPC_EINT: begin
							int_en <= ~int_en;
							state  <= FETCH_LATCH;
						end
						default: state <= FETCH_LATCH;
					endcase
				end
				EX2: state <= (opcode == `OPC_XCH) ? EX3 : FETCH_LATCH;
				default: state <= FETCH_LATCH;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu (
	input  logic [`OP_W-1:0]    op,
	input  logic [`DATA_W-1:0]  a,
	input  logic [`DATA_W-1:0]  b,
	input  logic [3:0]          imm,
	output logic [`DATA_W-1:0]  y
);

	always_comb begin
		y = a;    // pass r0 by default
		if (!op[`OP_W-1]) begin
			case (op[`OPC_W-1:0])
				`OPC_ADD: y = a + b;
				`OPC_SUB: y = a - b;
				`OPC_AND: y = a & b;
				`OPC_XOR: y = a ^ b;
				`OPC_LDI: y = {{(`DATA_W-4){1'b0}}, imm};
				default:  y = a;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module reg_bank (
	input  logic                clk,
	input  logic                nRst,
	input  cpu_pkg::ctrl_t      ctrl,
	input  cpu_pkg::instr_t     instr,
	input  logic [`DATA_W-1:0]  alu_y,
	input  logic [`DATA_W-1:0]  rdata,
	output logic [`DATA_W-1:0]  r0,
	output logic [`DATA_W-1:0]  rn
);

	logic [`DATA_W-1:0] regs [0:3];
	logic [`DATA_W-1:0] t;      // hidden, only xch uses it
	logic [1:0]         idx;

	assign idx = instr.as_reg.rn;
	assign r0  = regs[0];       // accumulator
	assign rn  = regs[idx];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
			t <= '0;
		end else if (ctrl.rb_we) begin
			case (ctrl.rb_sel)
				`RB_ALU_R0: regs[0]   <= alu_y;
				`RB_BUS_R0: regs[0]   <= rdata;
				`RB_R0_RN:  regs[idx] <= regs[0];
				`RB_RN_T:   t         <= regs[idx];
				`RB_T_R0:   regs[0]   <= t;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/addr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module addr_unit (
	input  logic                clk,
	input  logic                nRst,
	input  cpu_pkg::ctrl_t      ctrl,
	input  logic [`DATA_W-1:0]  r0,
	input  logic [`DATA_W-1:0]  rn,
	output cpu_pkg::bus_t       bus
);

	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] lr;       // return address for reti
	logic [`DATA_W-1:0] pc_next;

	always_comb begin
		case (ctrl.op)
			`OP_PC_OUT:  pc_next = pc + 1'b1;
			`OP_INT_VEC: pc_next = `INT_VECTOR;
			`OP_JMP_RN:  pc_next = rn;
			`OP_RETI:    pc_next = lr;
			default:     pc_next = pc;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
			lr <= '0;
		end else begin
			if (ctrl.pc_we)
				pc <= pc_next;
			if (ctrl.sp_we)
				lr <= pc;    // pc not yet advanced past vector
		end
	end

	// drive the shared ad lines
	always_comb begin
		bus.ale = ctrl.ale;
		bus.we  = ctrl.mem_we;
		case (ctrl.op)
			`OP_ADDR_RN:    bus.ad = rn;
			`OP_STORE_DATA: bus.ad = r0;
			default:        bus.ad = pc;    // fetch and idle
		endcase
	end

endmodule

`default_nettype wire

// File: source/up_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module up_core (
	input  logic                clk,
	input  logic                nRst,
	input  logic                irq,
	input  logic [`DATA_W-1:0]  rdata,
	output cpu_pkg::bus_t       bus
);

	cpu_pkg::ctrl_t     ctrl;
	cpu_pkg::instr_t    ir;
	logic [`DATA_W-1:0] alu_y;
	logic [`DATA_W-1:0] r0;
	logic [`DATA_W-1:0] rn;

	// instruction register, loaded in FETCH_READ
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst)
			ir <= '0;
		else if (ctrl.ir_we)
			ir <= rdata;
	end

	up_controller u_up_controller (
		.clk    (clk),
		.nRst   (nRst),
		.irq    (irq),
		.opcode (ir.as_imm.opcode),
		.ctrl   (ctrl)
	);

	alu u_alu (
		.op  (ctrl.op),
		.a   (r0),
		.b   (rn),
		.imm (ir.as_imm.imm),
		.y   (alu_y)
	);

	reg_bank u_reg_bank (
		.clk   (clk),
		.nRst  (nRst),
		.ctrl  (ctrl),
		.instr (ir),
		.alu_y (alu_y),
		.rdata (rdata),
		.r0    (r0),
		.rn    (rn)
	);

	addr_unit u_addr_unit (
		.clk  (clk),
		.nRst (nRst),
		.ctrl (ctrl),
		.r0   (r0),
		.rn   (rn),
		.bus  (bus)
	);

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_mem_model (
	input  logic                clk,
	input  logic                load,       // copy image in, clear log
	input  logic [`DATA_W-1:0]  image [0:255],
	input  cpu_pkg::bus_t       bus,
	output logic [`DATA_W-1:0]  rdata
);

	logic [`DATA_W-1:0] mem [0:255];
	logic [`DATA_W-1:0] addr_q = '0;
	logic [`DATA_W-1:0] log_addr [0:31];
	logic [`DATA_W-1:0] log_data [0:31];
	int                 log_count = 0;

	assign rdata = mem[addr_q];    // always ready, no wait states

	always @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= image[i];
			end
			addr_q    <= '0;
			log_count <= 0;
		end else begin
			if (bus.ale)
				addr_q <= bus.ad;
			if (bus.we) begin
				mem[addr_q] <= bus.ad;
				// keep the first 32 stores of a test
				if (log_count < 32) begin
					log_addr[log_count[4:0]] <= addr_q;
					log_data[log_count[4:0]] <= bus.ad;
				end
				log_count <= log_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_up_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_up_core;

	localparam int CLK_PERIOD = 8;
	localparam int START      = 4;    // reset pulse plus idle start cycle
	localparam int SLACK      = 4;
	localparam int ALU_RUN    = 4*3 + 4;
	localparam int XCH_RUN    = 4*3 + 4 + 5 + 4 + 5 + 4;
	localparam int JMP_RUN    = 4*3 + 4;
	localparam int QUIET      = 16;
	localparam int IRQ_DELAY  = 20;
	localparam int IRQ_RUN    = 3 + 1 + 5*3 + 4 + 3 + 4;    // loop, vector, handler, return
	localparam int FETCHES    = 8;
	localparam int TEST_CYC   = 4*(START + ALU_RUN + SLACK) + (START + XCH_RUN + SLACK)
		+ (START + JMP_RUN + SLACK + QUIET) + 2*(START + IRQ_DELAY + IRQ_RUN + SLACK)
		+ (START + FETCHES*3 + SLACK);

	logic               clk;
	logic               nRst;
	logic               irq;
	logic               load;
	logic [`DATA_W-1:0] rdata;
	logic [`DATA_W-1:0] image [0:255];
	cpu_pkg::bus_t      bus;
	integer             seed;
	int                 errors;
	int                 checks;

	up_core u_up_core (
		.clk   (clk),
		.nRst  (nRst),
		.irq   (irq),
		.rdata (rdata),
		.bus   (bus)
	);

	tb_mem_model u_mem (
		.clk   (clk),
		.load  (load),
		.image (image),
		.bus   (bus),
		.rdata (rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_write(input int idx, input int addr, input int data);
		check_value("store address", int'(u_mem.log_addr[idx[4:0]]), addr);
		check_value("store data", int'(u_mem.log_data[idx[4:0]]), data);
	endtask

	task automatic clear_image();
		logic [7:0] a;
		for (int i = 0; i < 256; i++) begin
			a = 8'(i);
			// nop opcodes with low bits mixed from the whole address
			image[i] = 8'hc0 | ((a ^ {a[1:0], a[7:2]}) & 8'h3f);
		end
	endtask

	task automatic reset_and_load();
		@(posedge clk);
		#1;
		nRst = 1'b0;
		irq  = 1'b0;
		load = 1'b1;
		@(posedge clk);
		#1;
		load = 1'b0;
		@(posedge clk);
		#1;
		nRst = 1'b1;
	endtask

	task automatic wait_for_writes(input int n, input int max_cyc, input string what);
		int k;
		k = 0;
		while (u_mem.log_count < n && k < max_cyc) begin
			@(negedge clk);
			k++;
		end
		if (u_mem.log_count < n) begin
			errors++;
			$display("%s: only %0d of %0d stores within %0d cycles", what, u_mem.log_count,
				n, max_cyc);
		end
	endtask

	task automatic test_alu();
		int         k;
		logic [3:0] a;
		logic [3:0] b;
		logic [7:0] exp;
		for (k = 0; k < 4; k++) begin
			a = 4'($random(seed));
			b = 4'($random(seed));
			case (k)
				0: exp = {4'h0, a} + {4'h0, b};
				1: exp = {4'h0, a} - {4'h0, b};
				2: exp = {4'h0, a & b};
				default: exp = {4'h0, a ^ b};
			endcase
			clear_image();
			image[0] = {`OPC_LDI, b};
			image[1] = {`OPC_MOV, 4'd1};
			image[2] = {`OPC_LDI, a};
			image[3] = {4'(k), 4'd1};    // add, sub, and, xor sit at opcodes 0..3
			image[4] = {`OPC_ST, 4'd3};  // r3 still 0 from reset
			reset_and_load();
			wait_for_writes(1, ALU_RUN + SLACK, "alu");
			check_write(0, 0, int'(exp));
		end
	endtask

	task automatic test_load_xch();
		logic [7:0] d;
		d = 8'($random(seed));
		clear_image();
		image[0]  = {`OPC_LDI, 4'd15};
		image[1]  = {`OPC_MOV, 4'd1};
		image[2]  = {`OPC_LDI, 4'd7};
		image[3]  = {`OPC_MOV, 4'd2};
		image[4]  = {`OPC_LD, 4'd1};     // r0 holds 7, not the address
		image[5]  = {`OPC_XCH, 4'd2};
		image[6]  = {`OPC_ST, 4'd3};
		image[7]  = {`OPC_XCH, 4'd2};    // swap back so r0 gets the loaded byte
		image[8]  = {`OPC_ST, 4'd3};
		image[15] = d;
		reset_and_load();
		wait_for_writes(2, XCH_RUN + SLACK, "load and exchange");
		check_write(0, 0, 7);
		check_write(1, 0, int'(d));
	endtask

	task automatic test_jump();
		int k;
		clear_image();
		image[0] = {`OPC_LDI, 4'd8};
		image[1] = {`OPC_MOV, 4'd1};
		image[2] = {`OPC_LDI, 4'd5};
		image[3] = {`OPC_JMP, 4'd1};
		image[4] = {`OPC_LDI, 4'd15};    // skipped
		for (k = 5; k < 9; k++)
			image[k] = {`OPC_ST, 4'd3};
		reset_and_load();
		wait_for_writes(1, JMP_RUN + SLACK, "jump");
		check_write(0, 0, 5);
		repeat (QUIET) @(negedge clk);
		check_value("store count after jump", u_mem.log_count, 1);
	endtask

	task automatic test_irq(input bit enable);
		clear_image();
		image[0]     = {`OPC_LDI, 4'd3};
		image[1]     = {`OPC_MOV, 4'd1};
		image[2]     = enable ? {`OPC_EINT, 4'd0} : 8'hc0;
		image[3]     = {`OPC_JMP, 4'd1};    // spin here
		image[4]     = {`OPC_LDI, 4'd15};   // reached only on a bad return address
		image[5]     = {`OPC_ST, 4'd3};
		image[8'h80] = {`OPC_LDI, 4'd9};
		image[8'h81] = {`OPC_ST, 4'd3};
		image[8'h82] = {`OPC_LDI, 4'd5};
		image[8'h83] = {`OPC_MOV, 4'd1};    // spin loop now jumps to the st
		image[8'h84] = {`OPC_LDI, 4'd12};
		image[8'h85] = {`OPC_RETI, 4'd0};
		reset_and_load();
		repeat (IRQ_DELAY) @(posedge clk);
		#1;
		irq = 1'b1;
		if (enable) begin
			wait_for_writes(2, IRQ_RUN + SLACK, "interrupt");
			check_write(0, 0, 9);
			check_write(1, 0, 12);
		end else begin
			repeat (IRQ_RUN + SLACK) @(negedge clk);
			check_value("store count with irq masked", u_mem.log_count, 0);
		end
		@(posedge clk);
		#1;
		irq = 1'b0;
	endtask

	task automatic test_fetch_timing();
		int cyc;
		int seen;
		int last;
		clear_image();
		image[0] = {`OPC_LDI, 4'd3};
		image[1] = {`OPC_MOV, 4'd1};
		image[2] = {`OPC_ADD, 4'd1};
		image[3] = {`OPC_SUB, 4'd2};
		image[4] = {`OPC_AND, 4'd1};
		image[5] = {`OPC_XOR, 4'd0};
		reset_and_load();
		cyc  = 0;
		seen = 0;
		last = 0;
		while (seen < FETCHES && cyc < START + FETCHES*3 + SLACK) begin
			@(negedge clk);
			cyc++;
			if (bus.ale) begin
				check_value("bus.ad at fetch", int'(bus.ad), seen);
				if (seen > 0)
					check_value("cycles between fetches", cyc - last, 3);
				last = cyc;
				seen++;
			end
		end
		if (seen < FETCHES) begin
			errors++;
			$display("fetch timing: saw %0d of %0d fetch cycles", seen, FETCHES);
		end
	endtask

	initial begin
		#(TEST_CYC * 2 * CLK_PERIOD);
		$display("timeout: run exceeded %0d cycles", TEST_CYC * 2);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed   = 32'hffa28cd5;
		nRst   = 1'b0;
		irq    = 1'b0;
		load   = 1'b0;
		errors = 0;
		checks = 0;
		clear_image();
		test_alu();
		test_load_xch();
		test_jump();
		test_irq(1'b1);
		test_irq(1'b0);
		test_fetch_timing();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/cpu_pkg.sv
source/up_controller.sv
source/alu.sv
source/reg_bank.sv
source/addr_unit.sv
source/up_core.sv
testbench/tb_mem_model.sv
testbench/tb_up_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the up_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_up_core -Mdir obj_dir
./obj_dir/Vtb_up_core > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
